//--- icache_pkg.sv
//##########################################################################
// cache geometry, fetch port structs and controller states
// imported by every instruction cache module
//##########################################################################
`default_nettype none

package icache_pkg;

  // byte address and instruction word
  localparam int addr_w = 32;
  localparam int word_w = 32;

  // direct mapped, 4 lines of 4 words
  localparam int line_words = 4;
  localparam int num_lines  = 4;
  localparam int offset_w   = 2;
  localparam int index_w    = 2;
  // pc split as tag | index | offset | byte
  localparam int tag_w      = addr_w - index_w - offset_w - 2;

  // credits held by the core after reset, also ingress depth
  localparam int fetch_credits = 4;
  localparam int ingress_ptr_w = $clog2(fetch_credits);

  // fetch request, low two pc bits ignored
  typedef struct packed {
    logic [addr_w-1:0] pc;
  } fetch_req_t;

  // fetch response, pc echoed with the instruction
  typedef struct packed {
    logic [addr_w-1:0] pc;
    logic [word_w-1:0] inst;
  } fetch_resp_t;

  // one cache line, word 0 at the lowest address
  typedef logic [line_words-1:0][word_w-1:0] line_t;

  // controller states
  typedef enum logic [1:0] {
    idle      = 2'd0,
    lookup    = 2'd1,
    fill_wait = 2'd2,
    respond   = 2'd3
  } cache_state_e;

endpackage

`default_nettype wire

//--- axi_read_pkg.sv
//##########################################################################
// AXI4 read channel payloads and the burst constants for line fills
// imported by the burst reader, used in the top-level port list
//##########################################################################
`default_nettype none

package axi_read_pkg;

  localparam int axi_addr_w = 32;
  localparam int axi_data_w = 32;

  // AxBURST encodings
  typedef enum logic [1:0] {
    fixed = 2'b00,
    incr  = 2'b01,
    wrap  = 2'b10
  } axi_burst_e;

  // read address channel payload, 45 bits
  typedef struct packed {
    logic [axi_addr_w-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    axi_burst_e            burst;
  } axi_ar_t;

  // read data channel payload, resp not carried
  typedef struct packed {
    logic [axi_data_w-1:0] data;
    logic                  last;
  } axi_r_t;

  // 4 beats of 4 bytes per line
  localparam logic [7:0] ar_len_line  = 8'd3;
  localparam logic [2:0] ar_size_word = 3'd2;

endpackage

`default_nettype wire

//--- fetch_ingress.sv
//##########################################################################
// credit based request buffer between the core fetch stage and the cache
// one credit comes back per entry the cache takes
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module fetch_ingress (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   req_valid,
  input  icache_pkg::fetch_req_t req,
  input  logic                   head_pop,
  output logic                   head_valid,
  output icache_pkg::fetch_req_t head,
  output logic                   credit_return
);
  import icache_pkg::*;

  // request slots
  fetch_req_t slots [fetch_credits];

  logic [ingress_ptr_w-1:0] wr_ptr;
  logic [ingress_ptr_w-1:0] rd_ptr;
  // one extra bit so a full buffer is representable
  logic [ingress_ptr_w:0]   count;
  logic                     push;
  logic                     pop;

  // core only sends while holding a credit, so no overflow check
  assign push = req_valid;
  assign pop  = head_pop && head_valid;

  assign head_valid = (count != '0);
  assign head       = slots[rd_ptr];

  always_ff @(posedge clock) begin
    if (push) begin
      slots[wr_ptr] <= req;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // credit back the cycle after the slot frees
  always_ff @(posedge clock) begin
    if (reset) begin
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop;
    end
  end

endmodule

`default_nettype wire

//--- icache_core.sv
//##########################################################################
// direct mapped cache arrays and the lookup / miss controller
// takes one request at a time from the ingress, answers in order
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module icache_core (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          head_valid,
  input  icache_pkg::fetch_req_t        head,
  input  logic                          fence_i,
  output logic                          head_pop,
  output logic                          resp_valid,
  output icache_pkg::fetch_resp_t       resp,
  output logic                          fill_start,
  output logic [icache_pkg::addr_w-1:0] fill_addr,
  input  logic                          fill_done,
  input  icache_pkg::line_t             fill_line
);
  import icache_pkg::*;

  cache_state_e state;

  // line storage with a tag and valid bit per line
  line_t                data_arr [num_lines];
  logic [tag_w-1:0]     tag_arr [num_lines];
  logic [num_lines-1:0] valid_arr;

  // request being served
  logic [addr_w-1:0]    pc_q;
  logic [tag_w-1:0]     pc_tag;
  logic [index_w-1:0]   pc_index;
  logic [offset_w-1:0]  pc_offset;

  logic hit;
  logic fill_sent;
  logic fill_finish;

  // address fields
  assign pc_offset = pc_q[offset_w+1:2];
  assign pc_index  = pc_q[index_w+offset_w+1:offset_w+2];
  assign pc_tag    = pc_q[addr_w-1:addr_w-tag_w];

  assign hit = valid_arr[pc_index] && (tag_arr[pc_index] == pc_tag);

  // next head only once the previous response is out
  assign head_pop = (state == idle) && head_valid && !resp_valid;

  // line aligned refill address
  assign fill_addr = {pc_q[addr_w-1:offset_w+2], {(offset_w + 2){1'b0}}};

  // fill is only expected while waiting for it
  assign fill_finish = (state == fill_wait) && fill_done;

  always_ff @(posedge clock) begin
    if (head_pop) begin
      pc_q <= head.pc;
    end
  end

  // controller
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (head_pop) begin
            state <= lookup;
          end
        end
        lookup: begin
          // tag compare on the registered pc
          state <= hit ? respond : fill_wait;
        end
        fill_wait: begin
          if (fill_done) begin
            state <= idle;
          end
        end
        respond: begin
          state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // single refill request per miss, one cycle into fill_wait
  always_ff @(posedge clock) begin
    if (reset) begin
      fill_start <= 1'b0;
      fill_sent  <= 1'b0;
    end else begin
      fill_start <= (state == fill_wait) && !fill_sent;
      fill_sent  <= (state == fill_wait);
    end
  end

  // response strobe
  always_ff @(posedge clock) begin
    if (reset) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= (state == respond) || fill_finish;
    end
  end

  // response payload
  // miss word taken straight from the incoming line
  always_ff @(posedge clock) begin
    if (state == respond) begin
      resp.pc   <= pc_q;
      resp.inst <= data_arr[pc_index][pc_offset];
    end else if (fill_finish) begin
      resp.pc   <= pc_q;
      resp.inst <= fill_line[pc_offset];
    end
  end

  // line and tag written with the response
  always_ff @(posedge clock) begin
    if (fill_finish) begin
      data_arr[pc_index] <= fill_line;
      tag_arr[pc_index]  <= pc_tag;
    end
  end

  // fence.i drops everything, a finishing fill still lands valid
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_arr <= '0;
    end else begin
      if (fence_i) begin
        valid_arr <= '0;
      end
      if (fill_finish) begin
        valid_arr[pc_index] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- axi_burst_reader.sv
//##########################################################################
// AXI4 read master for one line fill at a time
// issues a 4 beat incrementing burst and assembles the line
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module axi_burst_reader (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          fill_start,
  input  logic [icache_pkg::addr_w-1:0] fill_addr,
  output logic                          fill_done,
  output icache_pkg::line_t             fill_line,
  output logic                          arvalid,
  input  logic                          arready,
  output axi_read_pkg::axi_ar_t         ar,
  input  logic                          rvalid,
  output logic                          rready,
  input  axi_read_pkg::axi_r_t          r
);
  import icache_pkg::*;
  import axi_read_pkg::*;

  // latched line address, held stable under arvalid
  logic [addr_w-1:0]   line_addr;
  // burst in flight, gates stray beats
  logic                busy;
  logic [offset_w-1:0] beat_cnt;
  line_t               line_buf;
  logic                beat;

  // R channel never stalls
  assign rready = 1'b1;
  assign beat   = busy && rvalid && rready;

  assign ar = '{addr: line_addr, len: ar_len_line, size: ar_size_word, burst: incr};

  assign fill_line = line_buf;

  always_ff @(posedge clock) begin
    if (fill_start) begin
      line_addr <= fill_addr;
    end
  end

  // AR handshake and burst tracking
  always_ff @(posedge clock) begin
    if (reset) begin
      arvalid <= 1'b0;
      busy    <= 1'b0;
    end else begin
      if (fill_start) begin
        arvalid <= 1'b1;
      end else if (arvalid && arready) begin
        arvalid <= 1'b0;
      end
      if (fill_start) begin
        busy <= 1'b1;
      end else if (beat && r.last) begin
        busy <= 1'b0;
      end
    end
  end

  // beats arrive in address order
  always_ff @(posedge clock) begin
    if (reset) begin
      beat_cnt  <= '0;
      fill_done <= 1'b0;
    end else begin
      fill_done <= beat && r.last;
      if (beat) begin
        beat_cnt <= r.last ? '0 : beat_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (beat) begin
      line_buf[beat_cnt] <= r.data;
    end
  end

endmodule

`default_nettype wire

//--- icache_top.sv
//##########################################################################
// instruction cache top level, fetch port on one side, AXI4 read on other
// ingress buffer, cache controller and line fill master
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module icache_top (
  input  logic                    clock,
  input  logic                    reset,
  // fetch request, credit flow control
  input  logic                    req_valid,
  input  icache_pkg::fetch_req_t  req,
  output logic                    credit_return,
  // fetch response, always accepted
  output logic                    resp_valid,
  output icache_pkg::fetch_resp_t resp,
  input  logic                    fence_i,
  // AXI4 read
  output logic                    arvalid,
  input  logic                    arready,
  output axi_read_pkg::axi_ar_t   ar,
  input  logic                    rvalid,
  output logic                    rready,
  input  axi_read_pkg::axi_r_t    r
);
  import icache_pkg::*;

  // ingress to controller
  logic              head_valid;
  fetch_req_t        head;
  logic              head_pop;
  // controller to fill master
  logic              fill_start;
  logic [addr_w-1:0] fill_addr;
  logic              fill_done;
  line_t             fill_line;

  fetch_ingress u_ingress (
    .clock         (clock),
    .reset         (reset),
    .req_valid     (req_valid),
    .req           (req),
    .head_pop      (head_pop),
    .head_valid    (head_valid),
    .head          (head),
    .credit_return (credit_return)
  );

  icache_core u_core (
    .clock      (clock),
    .reset      (reset),
    .head_valid (head_valid),
    .head       (head),
    .fence_i    (fence_i),
    .head_pop   (head_pop),
    .resp_valid (resp_valid),
    .resp       (resp),
    .fill_start (fill_start),
    .fill_addr  (fill_addr),
    .fill_done  (fill_done),
    .fill_line  (fill_line)
  );

  axi_burst_reader u_reader (
    .clock      (clock),
    .reset      (reset),
    .fill_start (fill_start),
    .fill_addr  (fill_addr),
    .fill_done  (fill_done),
    .fill_line  (fill_line),
    .arvalid    (arvalid),
    .arready    (arready),
    .ar         (ar),
    .rvalid     (rvalid),
    .rready     (rready),
    .r          (r)
  );

endmodule

`default_nettype wire

//--- tb_axi_memory.sv
//##########################################################################
// testbench AXI4 read slave with random AR stalls and beat gaps
// each word is a fixed mix of its word address
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module tb_axi_memory (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  arvalid,
  output logic                  arready,
  input  axi_read_pkg::axi_ar_t ar,
  output logic                  rvalid,
  input  logic                  rready,
  output axi_read_pkg::axi_r_t  r
);
  import axi_read_pkg::*;

  // burst in progress
  logic        busy;
  // cycles of arready low still to go
  logic [1:0]  ar_delay;
  // idle cycles before the next beat
  logic [1:0]  gap;
  logic [31:0] beat_addr;
  logic [7:0]  beats_left;

  // same mixing as the reference in the testbench top
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [29:0] wa;
    wa = addr[31:2];
    return ({2'b00, wa} * 32'h9e37_79b1) ^ {wa[13:0], wa[29:12]} ^ 32'h5a5a_0f0f;
  endfunction

  initial begin
    arready = 1'b0;
    rvalid  = 1'b0;
    r       = '0;
  end

  always @(posedge clock) begin
    if (reset) begin
      arready    <= 1'b0;
      rvalid     <= 1'b0;
      r          <= '0;
      busy       <= 1'b0;
      ar_delay   <= 2'($urandom % 4);
      gap        <= 2'd0;
      beat_addr  <= '0;
      beats_left <= '0;
    end else begin
      // address handshake, stall for the next burst drawn here
      if (arvalid && arready) begin
        arready    <= 1'b0;
        busy       <= 1'b1;
        beat_addr  <= ar.addr;
        beats_left <= ar.len;
        gap        <= 2'($urandom % 3);
        ar_delay   <= 2'($urandom % 4);
      end else if (!busy) begin
        // zero delay means arready already up before arvalid
        if (ar_delay == 2'd0 || (arvalid && ar_delay == 2'd1)) begin
          arready <= 1'b1;
        end
        if (arvalid && ar_delay != 2'd0) begin
          ar_delay <= ar_delay - 2'd1;
        end
      end
      // data beats in address order
      if (busy) begin
        if (rvalid && rready && r.last) begin
          rvalid <= 1'b0;
          busy   <= 1'b0;
        end else if (!rvalid || rready) begin
          if (gap == 2'd0) begin
            rvalid     <= 1'b1;
            r          <= '{data: mem_word(beat_addr), last: (beats_left == 8'd0)};
            beat_addr  <= beat_addr + 32'd4;
            beats_left <= beats_left - 8'd1;
            gap        <= 2'($urandom % 3);
          end else begin
            rvalid <= 1'b0;
            gap    <= gap - 2'd1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_icache_top.sv
//##########################################################################
// testbench for the instruction cache top level
// credit based core model, reference cache model, AXI slave and checks
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module tb_icache_top;
  import icache_pkg::*;
  import axi_read_pkg::*;

  localparam int clock_period = 4;
  // 1 + 4 + 6 + 8 * 4 + 8 + 300 requests
  localparam int total_reqs   = 351;
  localparam int watchdog_ns  = (total_reqs * 40 + 200) * clock_period;

  logic        clock;
  logic        reset;
  logic        req_valid;
  fetch_req_t  req;
  logic        credit_return;
  logic        resp_valid;
  fetch_resp_t resp;
  logic        fence_i;
  logic        arvalid;
  logic        arready;
  axi_ar_t     ar;
  logic        rvalid;
  logic        rready;
  axi_r_t      r;

  // reference tag and valid state
  logic [num_lines-1:0] ref_valid;
  logic [tag_w-1:0]     ref_tag [num_lines];
  // core side credit count
  int                   credits;
  int                   cycle;
  // line fills seen on the AR channel
  int                   miss_count;
  bit                   lat_check;
  // expected traffic in order
  fetch_resp_t          exp_resp [$];
  axi_ar_t              exp_ar [$];
  int                   accept_cycle [$];

  icache_top dut (
    .clock         (clock),
    .reset         (reset),
    .req_valid     (req_valid),
    .req           (req),
    .credit_return (credit_return),
    .resp_valid    (resp_valid),
    .resp          (resp),
    .fence_i       (fence_i),
    .arvalid       (arvalid),
    .arready       (arready),
    .ar            (ar),
    .rvalid        (rvalid),
    .rready        (rready),
    .r             (r)
  );

  tb_axi_memory slave (
    .clock   (clock),
    .reset   (reset),
    .arvalid (arvalid),
    .arready (arready),
    .ar      (ar),
    .rvalid  (rvalid),
    .rready  (rready),
    .r       (r)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  // word address mixed into a data pattern
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [29:0] wa;
    wa = addr[31:2];
    return ({2'b00, wa} * 32'h9e37_79b1) ^ {wa[13:0], wa[29:12]} ^ 32'h5a5a_0f0f;
  endfunction

  function automatic fetch_resp_t expected_resp(input logic [31:0] pc);
    fetch_resp_t res;
    res.pc   = pc;
    res.inst = mem_word(pc);
    return res;
  endfunction

  task automatic check_resp(input fetch_resp_t expected, input fetch_resp_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: resp expected pc %h inst %h, got pc %h inst %h",
                          expected.pc, expected.inst, actual.pc, actual.inst));
    end
  endtask

  task automatic check_ar(input axi_ar_t expected, input axi_ar_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: ar expected %h (addr %h len %h), got %h (addr %h len %h)",
                          expected, expected.addr, expected.len,
                          actual, actual.addr, actual.len));
    end
  endtask

  // index is pc[5:4], tag is pc[31:6]
  // lines fill in request order, so a miss updates the model at issue
  task automatic predict(input logic [31:0] pc);
    logic [1:0]  idx;
    logic [25:0] tg;
    axi_ar_t     ar_exp;
    idx = pc[5:4];
    tg  = pc[31:6];
    if (!(ref_valid[idx] && ref_tag[idx] == tg)) begin
      ar_exp.addr  = {pc[31:4], 4'h0};
      ar_exp.len   = 8'd3;
      ar_exp.size  = 3'd2;
      ar_exp.burst = incr;
      exp_ar.push_back(ar_exp);
      ref_valid[idx] = 1'b1;
      ref_tag[idx]   = tg;
    end
    exp_resp.push_back(expected_resp(pc));
  endtask

  // credits after this edge, all from pre-edge values
  task automatic send_fetch(input logic [31:0] pc);
    @(posedge clock);
    while (credits + int'(credit_return) - int'(req_valid) <= 0) begin
      req_valid <= 1'b0;
      @(posedge clock);
    end
    req_valid <= 1'b1;
    req.pc    <= pc;
    predict(pc);
  endtask

  task automatic skip_cycle();
    @(posedge clock);
    req_valid <= 1'b0;
  endtask

  // wait for every outstanding response, sampled on the falling edge
  task automatic drain();
    @(posedge clock);
    req_valid <= 1'b0;
    @(negedge clock);
    while (exp_resp.size() != 0) begin
      @(negedge clock);
    end
  endtask

  task automatic pulse_fence();
    @(posedge clock);
    fence_i   <= 1'b1;
    ref_valid = '0;
    @(posedge clock);
    fence_i <= 1'b0;
  endtask

  // core credit counter
  always @(posedge clock) begin
    int next_credits;
    if (reset) begin
      credits <= fetch_credits;
    end else begin
      next_credits = credits + int'(credit_return) - int'(req_valid);
      if (next_credits < 0 || next_credits > fetch_credits) begin
        abort_run("credit count out of range, a request went out without a credit");
      end
      credits <= next_credits;
    end
  end

  // response and AR compare
  always @(posedge clock) begin
    int t0;
    if (reset) begin
      cycle      <= 0;
      miss_count <= 0;
    end else begin
      cycle <= cycle + 1;
      // R channel never stalls
      if (rready !== 1'b1) begin
        abort_run($sformatf("error: rready expected %h, got %h", 1'b1, rready));
      end
      if (req_valid) begin
        accept_cycle.push_back(cycle);
      end
      if (resp_valid) begin
        if (exp_resp.size() == 0) begin
          abort_run("a response came with no request outstanding");
        end
        check_resp(exp_resp.pop_front(), resp);
        t0 = accept_cycle.pop_front();
        // sampled 4 edges apart means 3 cycles after the accepting edge
        if (lat_check && (cycle - t0) != 4) begin
          abort_run($sformatf("hit answered %0d cycles after the request instead of 3",
                              cycle - t0 - 1));
        end
      end
      if (arvalid && arready) begin
        if (exp_ar.size() == 0) begin
          abort_run("an AR transfer went out for a request that should have hit");
        end
        check_ar(exp_ar.pop_front(), ar);
        miss_count <= miss_count + 1;
      end
    end
  end

  initial begin
    #(watchdog_ns);
    abort_run("timeout, the run did not finish in the expected number of cycles");
  end

  initial begin
    int i;
    int j;
    int misses_before;
    void'($urandom(32'hbef2_676d));
    reset      = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    fence_i    = 1'b0;
    ref_valid  = '0;
    lat_check  = 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    // cold miss
    send_fetch(32'h0000_1008);
    drain();

    // every word of the filled line, one at a time
    lat_check = 1'b1;
    for (i = 0; i < 4; i++) begin
      send_fetch(32'h0000_1000 + 32'(4 * i));
      drain();
    end
    lat_check = 1'b0;

    // same index, two tags
    for (i = 0; i < 6; i++) begin
      send_fetch(i[0] ? 32'h0000_3010 : 32'h0000_2010);
    end
    drain();

    // bursts of four under random slave stalls
    for (i = 0; i < 8; i++) begin
      for (j = 0; j < 4; j++) begin
        send_fetch(32'h0000_8000 + 4 * ($urandom % 32));
      end
      drain();
      if (credits != fetch_credits) begin
        abort_run("not all credits came back after a burst of four requests");
      end
    end

    // fill all lines, fence, then every line must refill
    for (i = 0; i < 4; i++) begin
      send_fetch(32'(16 * i));
    end
    drain();
    pulse_fence();
    misses_before = miss_count;
    for (i = 0; i < 4; i++) begin
      send_fetch(32'(20 * i));
    end
    drain();
    if (miss_count - misses_before != 4) begin
      abort_run("a line stayed cached across the fence.i pulse");
    end

    // random mix over a 64 word window
    for (i = 0; i < 300; i++) begin
      if ($urandom % 4 == 0) begin
        skip_cycle();
      end
      send_fetch(32'h0001_0000 + 4 * ($urandom % 64));
    end
    drain();

    @(negedge clock);
    if (exp_ar.size() != 0 || exp_resp.size() != 0 || credits != fetch_credits) begin
      abort_run("run ended with expected traffic pending or credits missing");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- icache_top.f
icache_pkg.sv
axi_read_pkg.sv
fetch_ingress.sv
icache_core.sv
axi_burst_reader.sv
icache_top.sv
tb_axi_memory.sv
tb_icache_top.sv

//--- run_sim.sh
#!/bin/sh
# build the cache testbench with Verilator, run it, judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_icache_top -f icache_top.f -o sim_icache \
  && ./obj_dir/sim_icache > sim.log 2>&1 \
  || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "TESTS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
